// ==== design/fetchDefs_defs.svh ====
// Fetch front end sizing
// LINE_BYTES must equal FETCH_WIDTH * INSN_BYTES, so a full group fills one line
// All sizes are powers of two; BTB_ENTRIES sets the index width
// RESET_PC must be aligned to INSN_BYTES

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Slots per fetch group
`define FETCH_WIDTH 4

// Fixed-length instructions
`define INSN_BYTES 4

// Instruction cache line size
`define LINE_BYTES 16

`define PC_WIDTH 32

// Direct-mapped, indexed by the word address bits
`define BTB_ENTRIES 16

`define RESET_PC 'h1000

`define SERIAL_WIDTH 16

`endif

// ==== design/fetchPkg.sv ====
// Shared types of the fetch front end
// BTB index and tag widths follow from BTB_ENTRIES and INSN_BYTES

`default_nettype none

`include "fetchDefs_defs.svh"

package fetchPkg;

    // Fetch or branch target address
    typedef logic [`PC_WIDTH-1:0] pcT;

    // Instruction serial number, counts from 1
    typedef logic [`SERIAL_WIDTH-1:0] serialT;

    // One valid bit per slot, slot 0 in bit 0
    typedef logic [`FETCH_WIDTH-1:0] slotMaskT;

    // Index sits just above the byte offset bits of the pc
    typedef logic [$clog2(`BTB_ENTRIES)-1:0] btbIndexT;

    // Tag is every pc bit above the index
    typedef logic [`PC_WIDTH-$clog2(`BTB_ENTRIES)-$clog2(`INSN_BYTES)-1:0] btbTagT;

endpackage

`default_nettype wire

// ==== design/fetchReqIf.sv ====
// Fetch group from the next-PC stage to the fetch stage
// Slots are contiguous from groupPc; groupSerial belongs to slot 0
// load is a plain level, there is no handshake

`timescale 1ns/1ps
`default_nettype none

interface fetchReqIf ();

    import fetchPkg::*;

    // First slot address of the group
    pcT       groupPc;

    // Slot mask, cleared past the line end
    slotMaskT slotValid;

    serialT   groupSerial;

    // Fetch register takes the group when high
    logic     load;

    modport source (
        output groupPc,
        output slotValid,
        output groupSerial,
        output load
    );

    modport sink (
        input  groupPc,
        input  slotValid,
        input  groupSerial,
        input  load
    );

endinterface

`default_nettype wire

// ==== design/fetchFeedbackIf.sv ====
// Fetch stage state and BTB prediction back to the next-PC stage
// predTaken is already masked while the previous cycle was stalled

`timescale 1ns/1ps
`default_nettype none

interface fetchFeedbackIf ();

    import fetchPkg::*;

    slotMaskT fetchValid;
    pcT       fetchPc;
    logic     predTaken;
    pcT       predTarget;

    // Stall seen in the previous cycle
    logic     stalledLast;

    modport source (
        output fetchValid,
        output fetchPc,
        output predTaken,
        output predTarget,
        output stalledLast
    );

    modport sink (
        input  fetchValid,
        input  fetchPc,
        input  predTaken,
        input  predTarget,
        input  stalledLast
    );

endinterface

`default_nettype wire

// ==== design/btbPredictor.sv ====
// Direct-mapped branch target buffer
// Four combinational lookups, one synchronous training write
// A write seen at an edge is visible to lookups in the next cycle
// Training not-taken invalidates the entry

`timescale 1ns/1ps
`default_nettype none

`include "fetchDefs_defs.svh"

module btbPredictor (
    input  logic               clk,
    input  logic               rstN,
    input  fetchPkg::pcT       lookupPc [`FETCH_WIDTH],
    input  logic               updateValid,
    input  fetchPkg::pcT       updatePc,
    input  fetchPkg::pcT       updateTarget,
    input  logic               updateTaken,
    output fetchPkg::slotMaskT hitTaken,
    output fetchPkg::pcT       hitTarget [`FETCH_WIDTH]
);

    import fetchPkg::*;

    localparam int InsnShift = $clog2(`INSN_BYTES);

    logic [`BTB_ENTRIES-1:0] entryValid;
    logic [`BTB_ENTRIES-1:0] entryTaken;
    btbTagT                  entryTag [`BTB_ENTRIES];
    pcT                      entryTarget [`BTB_ENTRIES];
    btbIndexT                updateIndex;

    function automatic btbIndexT toIndex(pcT pc);
        return pc[InsnShift +: $bits(btbIndexT)];
    endfunction

    function automatic btbTagT toTag(pcT pc);
        return pc[`PC_WIDTH-1 -: $bits(btbTagT)];
    endfunction

    assign updateIndex = toIndex(updatePc);

    // Lookup ports
    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : gLookup
        btbIndexT readIndex;
        logic     tagMatch;

        assign readIndex = toIndex(lookupPc[i]);
        assign tagMatch  = entryTag[readIndex] == toTag(lookupPc[i]);

        assign hitTaken[i]  = entryValid[readIndex] && tagMatch && entryTaken[readIndex];
        assign hitTarget[i] = entryTarget[readIndex];
    end

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (updateValid) begin
            entryValid[updateIndex] <= updateTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (updateValid) begin
            entryTag[updateIndex]    <= toTag(updatePc);
            entryTarget[updateIndex] <= updateTarget;
            entryTaken[updateIndex]  <= updateTaken;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
// Fetch group register and taken-branch prediction
// Register holds under stall, a clear arrives as an all-invalid group
// Slots after a predicted taken branch stay valid, trimming is done downstream
// Prediction is suppressed in any cycle that follows a stall cycle

`timescale 1ns/1ps
`default_nettype none

`include "fetchDefs_defs.svh"

module fetchStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               btbUpdateValid,
    input  fetchPkg::pcT       btbUpdatePc,
    input  fetchPkg::pcT       btbUpdateTarget,
    input  logic               btbUpdateTaken,
    fetchReqIf.sink            req,
    fetchFeedbackIf.source     fb,
    output fetchPkg::slotMaskT fetchSlotValid,
    output fetchPkg::pcT       fetchGroupPc,
    output fetchPkg::serialT   fetchSerial
);

    import fetchPkg::*;

    slotMaskT validQ;
    pcT       pcQ;
    serialT   serialQ;
    logic     stalledQ;
    pcT       lookupPc [`FETCH_WIDTH];
    slotMaskT hitTaken;
    pcT       hitTarget [`FETCH_WIDTH];
    logic     predTaken;
    pcT       predTarget;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ   <= '0;
            pcQ      <= pcT'(`RESET_PC);
            serialQ  <= serialT'(1);
            stalledQ <= 1'b0;
        end else begin
            stalledQ <= stall;
            if (req.load) begin
                validQ  <= req.slotValid;
                pcQ     <= req.groupPc;
                serialQ <= req.groupSerial;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lookupPc[i] = pcQ + pcT'(i * `INSN_BYTES);
        end
    end

    btbPredictor u_btbPredictor (
        .clk          (clk),
        .rstN         (rstN),
        .lookupPc     (lookupPc),
        .updateValid  (btbUpdateValid),
        .updatePc     (btbUpdatePc),
        .updateTarget (btbUpdateTarget),
        .updateTaken  (btbUpdateTaken),
        .hitTaken     (hitTaken),
        .hitTarget    (hitTarget)
    );

    // Lowest valid taken slot supplies the target
    always_comb begin
        predTaken  = 1'b0;
        predTarget = '0;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (!stalledQ && validQ[i] && hitTaken[i]) begin
                predTaken  = 1'b1;
                predTarget = hitTarget[i];
            end
        end
    end

    assign fb.fetchValid  = validQ;
    assign fb.fetchPc     = pcQ;
    assign fb.predTaken   = predTaken;
    assign fb.predTarget  = predTarget;
    assign fb.stalledLast = stalledQ;

    assign fetchSlotValid = validQ;
    assign fetchGroupPc   = pcQ;
    assign fetchSerial    = serialQ;

endmodule

`default_nettype wire

// ==== design/nextPcStage.sv ====
// Next-PC selection, group forming and serial numbering
// Priority of the selected address is redirect, BTB prediction, then the PC register
// Interrupt address goes into the PC register only, so its group comes two cycles later
// A group never crosses a cache line

`timescale 1ns/1ps
`default_nettype none

`include "fetchDefs_defs.svh"

module nextPcStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            stall,
    input  logic            clear,
    input  logic            redirectValid,
    input  fetchPkg::pcT    redirectPc,
    input  logic            interruptValid,
    input  fetchPkg::pcT    interruptPc,
    fetchReqIf.source       req,
    fetchFeedbackIf.sink    fb,
    output fetchPkg::pcT    icReadAddr
);

    import fetchPkg::*;

    localparam int LineShift = $clog2(`LINE_BYTES);

    pcT       pcReg;
    serialT   serialReg;
    pcT       selPc;
    pcT       pcNext;
    logic     beginStall;
    logic     pcWe;
    slotMaskT slotValid;
    logic [$clog2(`FETCH_WIDTH):0] leadCount;

    // True when the slot address lies in another line than the group start
    function automatic logic crossesLine(pcT basePc, pcT slotPc);
        return (basePc >> LineShift) != (slotPc >> LineShift);
    endfunction

    // First stall cycle, the selected group is not loaded and must be kept
    assign beginStall = stall && !fb.stalledLast;
    assign pcWe = !stall || beginStall || redirectValid || interruptValid;

    always_comb begin
        if (redirectValid) begin
            selPc = redirectPc;
        end else if (fb.predTaken) begin
            selPc = fb.predTarget;
        end else begin
            selPc = pcReg;
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slotValid[i] = !(clear || interruptValid ||
                             crossesLine(selPc, selPc + pcT'(i * `INSN_BYTES)));
        end
    end

    always_comb begin
        if (interruptValid) begin
            pcNext = interruptPc;
        end else if (beginStall) begin
            pcNext = selPc;
        end else begin
            pcNext = selPc + pcT'(`FETCH_WIDTH * `INSN_BYTES);
            // Walk down so the lowest crossing slot wins
            for (int i = `FETCH_WIDTH - 1; i > 0; i--) begin
                if (crossesLine(selPc, selPc + pcT'(i * `INSN_BYTES))) begin
                    pcNext = selPc + pcT'(i * `INSN_BYTES);
                end
            end
        end
    end

    // Count of valid slots from slot 0 up to the first invalid one
    always_comb begin
        logic run;
        run = 1'b1;
        leadCount = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            run = run && slotValid[i];
            if (run) begin
                leadCount = leadCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg     <= pcT'(`RESET_PC);
            serialReg <= serialT'(1);
        end else begin
            if (pcWe) begin
                pcReg <= pcNext;
            end
            if (!stall && !clear) begin
                serialReg <= serialReg + serialT'(leadCount);
            end
        end
    end

    assign req.groupPc     = selPc;
    assign req.slotValid   = slotValid;
    assign req.groupSerial = serialReg;
    assign req.load        = !stall;

    // Held group keeps the cache busy while stalled
    assign icReadAddr = (stall && fb.fetchValid[0]) ? fb.fetchPc : selPc;

endmodule

`default_nettype wire

// ==== design/fetchFrontTop.sv ====
// Fetch front end top level
// One cycle from selection to fetchGroupPc, no bubble after a predicted taken branch
// The instruction cache is outside, only its read address leaves here

`timescale 1ns/1ps
`default_nettype none

module fetchFrontTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               clear,
    input  logic               redirectValid,
    input  fetchPkg::pcT       redirectPc,
    input  logic               interruptValid,
    input  fetchPkg::pcT       interruptPc,
    input  logic               btbUpdateValid,
    input  fetchPkg::pcT       btbUpdatePc,
    input  fetchPkg::pcT       btbUpdateTarget,
    input  logic               btbUpdateTaken,
    output fetchPkg::slotMaskT fetchSlotValid,
    output fetchPkg::pcT       fetchGroupPc,
    output fetchPkg::serialT   fetchSerial,
    output fetchPkg::pcT       icReadAddr
);

    fetchReqIf      reqIf ();
    fetchFeedbackIf fbIf ();

    nextPcStage u_nextPcStage (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .clear          (clear),
        .redirectValid  (redirectValid),
        .redirectPc     (redirectPc),
        .interruptValid (interruptValid),
        .interruptPc    (interruptPc),
        .req            (reqIf),
        .fb             (fbIf),
        .icReadAddr     (icReadAddr)
    );

    fetchStage u_fetchStage (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .btbUpdateValid  (btbUpdateValid),
        .btbUpdatePc     (btbUpdatePc),
        .btbUpdateTarget (btbUpdateTarget),
        .btbUpdateTaken  (btbUpdateTaken),
        .req             (reqIf),
        .fb              (fbIf),
        .fetchSlotValid  (fetchSlotValid),
        .fetchGroupPc    (fetchGroupPc),
        .fetchSerial     (fetchSerial)
    );

endmodule

`default_nettype wire

// ==== sim/fetchChecker.sv ====
// Reference model of the fetch front end, compared with the DUT at every falling edge
// Registered outputs reflect the previous row, so the last effect of a test
// is checked under the name of the test that follows it

`timescale 1ns/1ps
`default_nettype none

`include "fetchDefs_defs.svh"

module fetchChecker (
    input  logic               clk,
    input  logic               rstN,
    input  logic [8*12-1:0]    testName,
    input  logic               done,
    input  logic               stall,
    input  logic               clear,
    input  logic               redirectValid,
    input  fetchPkg::pcT       redirectPc,
    input  logic               interruptValid,
    input  fetchPkg::pcT       interruptPc,
    input  logic               btbUpdateValid,
    input  fetchPkg::pcT       btbUpdatePc,
    input  fetchPkg::pcT       btbUpdateTarget,
    input  logic               btbUpdateTaken,
    input  fetchPkg::slotMaskT fetchSlotValid,
    input  fetchPkg::pcT       fetchGroupPc,
    input  fetchPkg::serialT   fetchSerial,
    input  fetchPkg::pcT       icReadAddr,
    output int                 errorCount,
    output int                 testCount
);

    import fetchPkg::*;

    // Model state: PC, serial, fetch register and BTB
    pcT              pcM;
    serialT          serialM;
    slotMaskT        validM;
    pcT              groupM;
    serialT          grpSerialM;
    logic            stalledM;
    logic            btbValid [`BTB_ENTRIES];
    pcT              btbPc [`BTB_ENTRIES];
    pcT              btbTarget [`BTB_ENTRIES];
    logic [8*12-1:0] curName;
    int              testErrors;
    logic            finished = 1'b0;

    task automatic compare(input string what, input pcT expVal, input pcT actVal);
        if (expVal !== actVal) begin
            $display("[ERROR] %0s %0s expected %h actual %h", curName, what, expVal, actVal);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic reportTest();
        if (testErrors == 0) begin
            $display("test %0s passed", curName);
        end else begin
            $display("test %0s failed with %0d errors", curName, testErrors);
        end
    endtask

    task automatic step();
        logic     predTaken;
        pcT       predTarget;
        pcT       sel;
        pcT       slotPc;
        int       idx;
        int       n;
        slotMaskT mask;
        predTaken  = 1'b0;
        predTarget = '0;
        // Lowest valid slot with a taken entry, nothing right after a stall cycle
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slotPc = groupM + i * `INSN_BYTES;
            idx    = (slotPc / `INSN_BYTES) % `BTB_ENTRIES;
            if (!predTaken && !stalledM && validM[i] && btbValid[idx] &&
                    btbPc[idx] / `INSN_BYTES == slotPc / `INSN_BYTES) begin
                predTaken  = 1'b1;
                predTarget = btbTarget[idx];
            end
        end
        sel = redirectValid ? redirectPc : (predTaken ? predTarget : pcM);
        // Slots run up to the end of the line
        n    = (clear || interruptValid) ? 0 : (`LINE_BYTES - sel % `LINE_BYTES) / `INSN_BYTES;
        mask = slotMaskT'((1 << n) - 1);

        compare("fetchSlotValid", pcT'(validM), pcT'(fetchSlotValid));
        compare("fetchGroupPc", groupM, fetchGroupPc);
        compare("fetchSerial", pcT'(grpSerialM), pcT'(fetchSerial));
        compare("icReadAddr", (stall && validM[0]) ? groupM : sel, icReadAddr);

        if (interruptValid) begin
            pcM = interruptPc;
        end else if (stall && !stalledM) begin
            pcM = sel;
        end else if (!stall || redirectValid) begin
            pcM = sel - sel % `LINE_BYTES + `LINE_BYTES;
        end
        if (!stall) begin
            validM     = mask;
            groupM     = sel;
            grpSerialM = serialM;
        end
        if (!stall && !clear) begin
            serialM = serialM + serialT'(n);
        end
        stalledM = stall;
        if (btbUpdateValid) begin
            idx            = (btbUpdatePc / `INSN_BYTES) % `BTB_ENTRIES;
            btbValid[idx]  = btbUpdateTaken;
            btbPc[idx]     = btbUpdatePc;
            btbTarget[idx] = btbUpdateTarget;
        end
    endtask

    always @(negedge clk) begin
        if (!rstN) begin
            pcM        = `RESET_PC;
            serialM    = 1;
            validM     = '0;
            groupM     = `RESET_PC;
            grpSerialM = 1;
            stalledM   = 1'b0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btbValid[i] = 1'b0;
            end
            curName    = testName;
            testErrors = 0;
            errorCount = 0;
            testCount  = 1;
        end else if (!finished) begin
            if (done) begin
                reportTest();
                finished = 1'b1;
            end else begin
                if (testName != curName) begin
                    reportTest();
                    curName    = testName;
                    testErrors = 0;
                    testCount++;
                end
                step();
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tbFetchFront.sv ====
// Testbench for the fetch front end
// One table row per cycle; fetchChecker holds the reference model
// Rows with randOff set add a random word offset inside the line to redirectPc

`timescale 1ns/1ps
`default_nettype none

`include "fetchDefs_defs.svh"

module tbFetchFront;

    import fetchPkg::*;

    localparam int ResetCycles = 3;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic            stall;
        logic            clear;
        logic            redir;
        pcT              redirPc;
        logic            randOff;
        logic            intr;
        pcT              intrPc;
        logic            upd;
        pcT              updPc;
        pcT              updTarget;
        logic            updTaken;
    } rowT;

    logic clk = 1'b0;
    logic rstN, stall, clear, redirectValid, interruptValid, btbUpdateValid, btbUpdateTaken;
    pcT   redirectPc, interruptPc, btbUpdatePc, btbUpdateTarget, icReadAddr, fetchGroupPc;
    slotMaskT        fetchSlotValid;
    serialT          fetchSerial;
    logic [8*12-1:0] testName;
    logic            done;
    int              errorCount;
    int              testCount;
    rowT             rows [0:63];
    int              rowCount = 0;
    int              cycleCount = 0;
    int              cycleLimit = 0;

    always #20 clk = ~clk;

    fetchFrontTop u_fetchFrontTop (
        .clk(clk), .rstN(rstN), .stall(stall), .clear(clear),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .interruptValid(interruptValid), .interruptPc(interruptPc),
        .btbUpdateValid(btbUpdateValid), .btbUpdatePc(btbUpdatePc),
        .btbUpdateTarget(btbUpdateTarget), .btbUpdateTaken(btbUpdateTaken),
        .fetchSlotValid(fetchSlotValid), .fetchGroupPc(fetchGroupPc),
        .fetchSerial(fetchSerial), .icReadAddr(icReadAddr)
    );

    fetchChecker u_fetchChecker (.*);

    task automatic addRow(input logic [8*12-1:0] name, input logic st, cl, rd, input pcT rPc,
                          input logic rnd, it, input pcT iPc, input logic up,
                          input pcT uPc, uTgt, input logic uTk);
        rows[rowCount] = {name, st, cl, rd, rPc, rnd, it, iPc, up, uPc, uTgt, uTk};
        rowCount++;
    endtask

    task automatic applyRow(input rowT row);
        testName        <= row.name;
        stall           <= row.stall;
        clear           <= row.clear;
        redirectValid   <= row.redir;
        redirectPc      <= row.randOff ? row.redirPc + ($urandom % 4) * `INSN_BYTES : row.redirPc;
        interruptValid  <= row.intr;
        interruptPc     <= row.intrPc;
        btbUpdateValid  <= row.upd;
        btbUpdatePc     <= row.updPc;
        btbUpdateTarget <= row.updTarget;
        btbUpdateTaken  <= row.updTaken;
    endtask

    task automatic buildTable();
        //     name           st cl rd redirPc   rn it intrPc    up updPc     updTarget   tk
        for (int i = 0; i < 4; i++) addRow("seq", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("redirect",     0, 0, 1, 32'h3008, 0, 0, 0,        0, 0,        0,          0);
        addRow("redirect",     0, 0, 0, 0,        0, 0, 0,        0, 0,        0,          0);
        addRow("redirect",     0, 0, 0, 0,        0, 0, 0,        0, 0,        0,          0);
        addRow("redirectRand", 0, 0, 1, 32'h3100, 1, 0, 0,        0, 0,        0,          0);
        addRow("redirectRand", 0, 0, 0, 0,        0, 0, 0,        0, 0,        0,          0);
        addRow("btbTaken",     0, 0, 1, 32'h4000, 0, 0, 0,        1, 32'h4004, 32'h5000,   1);
        for (int i = 0; i < 3; i++) addRow("btbTaken", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("btbRetrain",   0, 0, 1, 32'h4000, 0, 0, 0,        1, 32'h4004, 32'h5000,   0);
        for (int i = 0; i < 3; i++) addRow("btbRetrain", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        for (int i = 0; i < 3; i++) addRow("stall", 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        for (int i = 0; i < 2; i++) addRow("stall", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("interrupt",    0, 0, 1, 32'h9000, 0, 1, 32'h8000, 0, 0,        0,          0);
        for (int i = 0; i < 2; i++) addRow("interrupt", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("clear",        0, 1, 0, 0,        0, 0, 0,        0, 0,        0,          0);
        for (int i = 0; i < 2; i++) addRow("clear", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    initial begin
        void'($urandom(65));
        rstN = 1'b0;
        done = 1'b0;
        applyRow('0);
        testName <= "reset";
        buildTable();
        cycleLimit = rowCount + ResetCycles + 20;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int r = 0; r < rowCount; r++) begin
            @(posedge clk);
            applyRow(rows[r]);
        end
        @(posedge clk);
        done <= 1'b1;
        repeat (2) @(posedge clk);
        $display("%0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Guards against a run that never reaches the end of the table
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run hung after %0d cycles", cycleCount);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/fetchPkg.sv
design/fetchReqIf.sv
design/fetchFeedbackIf.sv
design/btbPredictor.sv
design/fetchStage.sv
design/nextPcStage.sv
design/fetchFrontTop.sv
sim/fetchChecker.sv
sim/tbFetchFront.sv

// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - include_dirs:
      - design
    files:
      - design/fetchPkg.sv
      - design/fetchReqIf.sv
      - design/fetchFeedbackIf.sv
      - design/btbPredictor.sv
      - design/fetchStage.sv
      - design/nextPcStage.sv
      - design/fetchFrontTop.sv
      - target: simulation
        files:
          - sim/fetchChecker.sv
          - sim/tbFetchFront.sv
